//--- verilog/motorPkg.sv
`default_nettype none

package motorPkg;

    // ********************
    // timing and sequence constants
    // ********************
    localparam int periodWidth = 25;
    localparam int stepCount   = 12;
    localparam int revWidth    = 16;

    localparam logic [3:0] stepIdle = 4'd15;   // any code >= stepCount is idle.
    localparam logic [3:0] offsetB  = 4'd8;    // 240 degrees.
    localparam logic [3:0] offsetC  = 4'd4;    // 120 degrees.

    localparam logic [periodWidth-1:0] periodDelta = 25'd16;
    localparam logic [periodWidth-1:0] periodMin   = 25'd2;
    localparam logic [periodWidth-1:0] periodMax   = {periodWidth{1'b1}};

    // phase pattern boundaries within the 12 steps.
    localparam logic [3:0] phaseHiLast  = 4'd3;
    localparam logic [3:0] phaseLoFirst = 4'd6;
    localparam logic [3:0] phaseLoLast  = 4'd9;

    // ********************
    // types
    // ********************
    typedef enum logic [2:0] {
        opSetPeriod = 3'd0,
        opSetSplit  = 3'd1,
        opStart     = 3'd2,
        opStop      = 3'd3,
        opFaster    = 3'd4,
        opSlower    = 3'd5
    } cmdOpT;

    typedef struct packed {
        logic                   valid;
        cmdOpT                  op;
        logic [periodWidth-1:0] data;
    } motorCmdT;

    typedef struct packed {
        logic [periodWidth-1:0] period;
        logic [1:0]             splitMax;
        logic                   run;
    } stepConfigT;

    typedef struct packed {
        logic [3:0] stepA;
        logic [3:0] stepB;
        logic [3:0] stepC;
        logic       active;
    } stepStateT;

    typedef struct packed {
        logic hiA;
        logic loA;
        logic hiB;
        logic loB;
        logic hiC;
        logic loC;
    } phaseDriveT;

endpackage

`default_nettype wire

//--- verilog/motorCmdDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module motorCmdDecoder (
    input  logic                 clk,
    input  logic                 reset,
    input  motorPkg::motorCmdT   cmd,
    output motorPkg::stepConfigT stepConfig
);

    logic [motorPkg::periodWidth-1:0] periodFaster;
    logic [motorPkg::periodWidth-1:0] periodSlower;
    logic [motorPkg::periodWidth-1:0] periodClamped;

    // ********************
    // period arithmetic
    // ********************
    always_comb begin
        // saturate at the fast end.
        if (stepConfig.period < motorPkg::periodMin + motorPkg::periodDelta) begin
            periodFaster = motorPkg::periodMin;
        end else begin
            periodFaster = stepConfig.period - motorPkg::periodDelta;
        end

        // saturate at the slow end.
        if (stepConfig.period > motorPkg::periodMax - motorPkg::periodDelta) begin
            periodSlower = motorPkg::periodMax;
        end else begin
            periodSlower = stepConfig.period + motorPkg::periodDelta;
        end

        // data is already limited to periodMax by its width.
        if (cmd.data < motorPkg::periodMin) begin
            periodClamped = motorPkg::periodMin;
        end else begin
            periodClamped = cmd.data;
        end
    end

    // ********************
    // configuration registers
    // ********************
    always_ff @(posedge clk) begin
        if (reset) begin
            stepConfig.period   <= motorPkg::periodMin;
            stepConfig.splitMax <= 2'd0;
            stepConfig.run      <= 1'b0;
        end else if (cmd.valid) begin
            case (cmd.op)
                motorPkg::opSetPeriod: begin
                    stepConfig.period <= periodClamped;
                end
                motorPkg::opSetSplit: begin
                    stepConfig.splitMax <= cmd.data[1:0];
                end
                motorPkg::opStart: begin
                    stepConfig.run <= 1'b1;
                end
                motorPkg::opStop: begin
                    stepConfig.run <= 1'b0;
                end
                motorPkg::opFaster: begin
                    stepConfig.period <= periodFaster;
                end
                motorPkg::opSlower: begin
                    stepConfig.period <= periodSlower;
                end
                default: begin
                    stepConfig.run <= stepConfig.run;   // unknown op ignored.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/stepGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module stepGenerator (
    input  logic                              clk,
    input  logic                              reset,
    input  motorPkg::stepConfigT              stepConfig,
    output motorPkg::stepStateT               state,
    output logic [motorPkg::revWidth-1:0]     revolutions
);

    logic                             runDly;
    logic                             runUp;
    logic [motorPkg::periodWidth-1:0] cnt;
    logic [1:0]                       split;
    logic [3:0]                       stepA;
    logic                             cntLast;
    logic                             stepAdvance;
    logic                             lastStep;
    logic                             active;

    // step position of a following phase, modulo 12.
    function automatic logic [3:0] wrapStep(input logic [3:0] step, input logic [3:0] offset);
        logic [4:0] sum;
        sum = step + offset;
        if (sum >= 5'(motorPkg::stepCount)) begin
            sum = sum - 5'(motorPkg::stepCount);
        end
        return sum[3:0];
    endfunction

    assign runUp       = stepConfig.run & ~runDly;
    assign cntLast     = (cnt[motorPkg::periodWidth-1:1] == '0);   // count of 1 or 0.
    assign stepAdvance = stepConfig.run & cntLast & (split == 2'd0);
    assign lastStep    = (stepA == 4'(motorPkg::stepCount - 1));
    assign active      = (stepA < 4'(motorPkg::stepCount));

    always_ff @(posedge clk) begin
        if (reset) begin
            runDly <= 1'b0;
        end else begin
            runDly <= stepConfig.run;
        end
    end

    // ********************
    // period and split counters
    // ********************
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt   <= '0;
            split <= 2'd0;
        end else if (runUp) begin
            cnt   <= stepConfig.period;
            split <= stepConfig.splitMax;
        end else if (stepConfig.run) begin
            if (cntLast) begin
                cnt <= stepConfig.period;   // new period applies here.
                if (split == 2'd0) begin
                    split <= stepConfig.splitMax;
                end else begin
                    split <= split - 2'd1;
                end
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // ********************
    // step sequence and revolutions
    // ********************
    always_ff @(posedge clk) begin
        if (reset || !stepConfig.run) begin
            stepA <= motorPkg::stepIdle;   // bridge released.
        end else if (runUp) begin
            stepA <= 4'd0;
        end else if (stepAdvance) begin
            stepA <= lastStep ? 4'd0 : stepA + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || runUp) begin
            revolutions <= '0;
        end else if (stepAdvance && lastStep) begin
            revolutions <= revolutions + 1'b1;   // wrap 11 to 0.
        end
    end

    always_comb begin
        state.active = active;
        if (active) begin
            state.stepA = stepA;
            state.stepB = wrapStep(stepA, motorPkg::offsetB);
            state.stepC = wrapStep(stepA, motorPkg::offsetC);
        end else begin
            state.stepA = motorPkg::stepIdle;
            state.stepB = motorPkg::stepIdle;
            state.stepC = motorPkg::stepIdle;
        end
    end

endmodule

`default_nettype wire

//--- verilog/phaseDriver.sv
`timescale 1ns/1ps
`default_nettype none

module phaseDriver (
    input  logic                 clk,
    input  logic                 reset,
    input  motorPkg::stepStateT  state,
    output motorPkg::phaseDriveT drive
);

    logic [1:0] levelA;
    logic [1:0] levelB;
    logic [1:0] levelC;

    // {hi, lo} for one phase; float outside the two windows.
    function automatic logic [1:0] phaseLevel(input logic [3:0] step);
        logic [1:0] level;
        level = 2'b00;
        if (step <= motorPkg::phaseHiLast) begin
            level = 2'b10;
        end else if (step >= motorPkg::phaseLoFirst && step <= motorPkg::phaseLoLast) begin
            level = 2'b01;
        end
        return level;
    endfunction

    // ********************
    // step to gate level
    // ********************
    always_comb begin
        if (state.active) begin
            levelA = phaseLevel(state.stepA);
            levelB = phaseLevel(state.stepB);
            levelC = phaseLevel(state.stepC);
        end else begin
            levelA = 2'b00;   // idle, all off.
            levelB = 2'b00;
            levelC = 2'b00;
        end
    end

    // ********************
    // output register
    // ********************
    always_ff @(posedge clk) begin
        if (reset) begin
            drive <= '0;
        end else begin
            drive.hiA <= levelA[1];
            drive.loA <= levelA[0];
            drive.hiB <= levelB[1];
            drive.loB <= levelB[0];
            drive.hiC <= levelC[1];
            drive.loC <= levelC[0];
        end
    end

endmodule

`default_nettype wire

//--- verilog/motorTop.sv
`timescale 1ns/1ps
`default_nettype none

module motorTop (
    input  logic                          clk,
    input  logic                          reset,
    input  motorPkg::motorCmdT            cmd,
    output motorPkg::phaseDriveT          drive,
    output logic [motorPkg::revWidth-1:0] revolutions
);

    motorPkg::stepConfigT stepConfig;
    motorPkg::stepStateT  state;

    // ********************
    // command side
    // ********************
    motorCmdDecoder i_cmdDecoder (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd),
        .stepConfig (stepConfig)
    );

    // ********************
    // sequencer
    // ********************
    stepGenerator i_stepGenerator (
        .clk         (clk),
        .reset       (reset),
        .stepConfig  (stepConfig),
        .state       (state),
        .revolutions (revolutions)
    );

    // ********************
    // gate outputs
    // ********************
    phaseDriver i_phaseDriver (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .drive (drive)
    );

endmodule

`default_nettype wire

//--- testbench/motorTop_sva.sv
`timescale 1ns/1ps
`default_nettype none

module motorTopSva (
    input logic                 clk,
    input logic                 reset,
    input motorPkg::stepStateT  state,
    input motorPkg::phaseDriveT drive
);

    // ********************
    // gate safety
    // ********************
    noShootThrough: assert property (@(posedge clk) disable iff (reset)
        !((drive.hiA && drive.loA) || (drive.hiB && drive.loB) || (drive.hiC && drive.loC)))
        else $error("high and low gate enabled together on one phase");

    driveClearAfterReset: assert property (@(posedge clk) reset |=> (drive == '0))
        else $error("gate enables not cleared after reset");

    // ********************
    // step codes
    // ********************
    idleCodeA: assert property (@(posedge clk) disable iff (reset)
        (state.stepA >= motorPkg::stepCount) |-> (state.stepA == motorPkg::stepIdle))
        else $error("phase A step out of range and not idle");

    idleCodeB: assert property (@(posedge clk) disable iff (reset)
        (state.stepB >= motorPkg::stepCount) |-> (state.stepB == motorPkg::stepIdle))
        else $error("phase B step out of range and not idle");

    idleCodeC: assert property (@(posedge clk) disable iff (reset)
        (state.stepC >= motorPkg::stepCount) |-> (state.stepC == motorPkg::stepIdle))
        else $error("phase C step out of range and not idle");

endmodule

bind motorTop motorTopSva i_sva (
    .clk   (clk),
    .reset (reset),
    .state (state),
    .drive (drive)
);

`default_nettype wire

//--- testbench/motorTb.sv
`timescale 1ns/1ps
`default_nettype none

module motorTb;

    localparam int tableSize   = 16;
    localparam int resetCycles = 16;

    logic                             clk;
    logic                             reset;
    motorPkg::motorCmdT               cmd;
    motorPkg::phaseDriveT             drive;
    logic [motorPkg::revWidth-1:0]    revolutions;

    motorPkg::cmdOpT                  tabOp [tableSize];
    logic [motorPkg::periodWidth-1:0] tabData [tableSize];
    int                               tabWait [tableSize];
    int                               tabRev [tableSize];
    int                               tabCount;

    // reference model.
    logic [motorPkg::periodWidth-1:0] mPeriod;
    logic [1:0]                       mSplitMax;
    logic                             mRun;
    logic                             mRunDly;
    logic [motorPkg::periodWidth-1:0] mCnt;
    logic [1:0]                       mSplit;
    int                               mStepA;
    logic [motorPkg::revWidth-1:0]    mRev;
    logic [5:0]                       mDrive;

    int                               cycleCount;
    int                               cycleLimit;
    logic [31:0]                      rngState;

    motorTop i_dut (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .drive       (drive),
        .revolutions (revolutions)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // {hi, lo} of one phase.
    function automatic logic [1:0] gateLevel(input int pos);
        case (pos)
            0, 1, 2, 3: return 2'b10;
            6, 7, 8, 9: return 2'b01;
            default:    return 2'b00;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic addEntry(input motorPkg::cmdOpT op, input int data, input int waitCycles,
                            input int expRev);
        tabOp[tabCount]   = op;
        tabData[tabCount] = data;
        tabWait[tabCount] = waitCycles;
        tabRev[tabCount]  = expRev;
        tabCount++;
    endtask

    task automatic loadTable();
        rngState = xorshift(rngState);
        addEntry(motorPkg::opSetPeriod, 2 + rngState % 39, 4, 0);   // stopped.
        addEntry(motorPkg::opFaster, 0, 4, 0);
        addEntry(motorPkg::opSetPeriod, 3, 4, 0);
        addEntry(motorPkg::opSetSplit, 1, 4, 0);
        addEntry(motorPkg::opStart, 0, 160, 2);   // 72 cycles per revolution.
        addEntry(motorPkg::opSlower, 0, 400, 3);
        addEntry(motorPkg::opFaster, 0, 100, 4);
        addEntry(motorPkg::opStop, 0, 20, 4);
        addEntry(motorPkg::opSetSplit, 0, 4, 4);
        addEntry(motorPkg::opSetPeriod, 2, 4, 4);
        addEntry(motorPkg::opFaster, 0, 4, 4);   // saturates at the fast end.
        addEntry(motorPkg::opStart, 0, 100, 4);   // 24 cycles per revolution.
        addEntry(motorPkg::opSetPeriod, 0, 50, 6);
        addEntry(motorPkg::opSetPeriod, 33554430, 60, 6);
        addEntry(motorPkg::opSlower, 0, 4, 6);   // saturates at the slow end.
        addEntry(motorPkg::opStop, 0, 8, 6);
    endtask

    // ********************
    // reference model
    // ********************
    always @(posedge clk) begin
        logic   runUp;
        logic   cntLast;
        longint target;
        if (reset) begin
            mPeriod   = motorPkg::periodMin;
            mSplitMax = 2'd0;
            mRun      = 1'b0;
            mRunDly   = 1'b0;
            mCnt      = '0;
            mSplit    = 2'd0;
            mStepA    = 15;
            mRev      = '0;
            mDrive    = '0;
        end else begin
            runUp   = mRun && !mRunDly;
            cntLast = (mCnt <= 1);
            if (mStepA < 12) begin
                mDrive = {gateLevel(mStepA), gateLevel((mStepA + 8) % 12),
                          gateLevel((mStepA + 4) % 12)};
            end else begin
                mDrive = '0;
            end
            if (!mRun) begin
                mStepA = 15;
            end else if (runUp) begin
                mStepA = 0;
                mRev   = '0;
            end else if (cntLast && mSplit == 2'd0) begin
                mRev   = (mStepA == 11) ? mRev + 1'b1 : mRev;
                mStepA = (mStepA + 1) % 12;
            end
            if (runUp || (mRun && cntLast)) begin
                mSplit = (runUp || mSplit == 2'd0) ? mSplitMax : mSplit - 2'd1;
                mCnt   = mPeriod;
            end else if (mRun) begin
                mCnt = mCnt - 1'b1;
            end
            mRunDly = mRun;
            if (cmd.valid) begin
                target = longint'(mPeriod);
                case (cmd.op)
                    motorPkg::opSetPeriod: target = longint'(cmd.data);
                    motorPkg::opSetSplit:  mSplitMax = cmd.data[1:0];
                    motorPkg::opStart:     mRun = 1'b1;
                    motorPkg::opStop:      mRun = 1'b0;
                    motorPkg::opFaster:    target = target - longint'(motorPkg::periodDelta);
                    motorPkg::opSlower:    target = target + longint'(motorPkg::periodDelta);
                    default:               target = longint'(mPeriod);
                endcase
                if (target < longint'(motorPkg::periodMin)) begin
                    target = longint'(motorPkg::periodMin);
                end else if (target > longint'(motorPkg::periodMax)) begin
                    target = longint'(motorPkg::periodMax);
                end
                mPeriod = target;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            checkValue("drive", drive, mDrive);
            checkValue("revolutions", revolutions, mRev);
            checkValue("stepConfig", i_dut.stepConfig, {mPeriod, mSplitMax, mRun});
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the command table did not finish within %0d cycles", cycleLimit);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    // ********************
    // stimulus
    // ********************
    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        cmd        = '0;
        cycleCount = 0;
        tabCount   = 0;
        rngState   = 32'd68565;
        loadTable();
        cycleLimit = resetCycles + 64;
        for (int i = 0; i < tabCount; i++) begin
            cycleLimit += tabWait[i] + 2;
        end
        repeat (resetCycles) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < tabCount; i++) begin
            @(posedge clk);
            #2;
            cmd.valid = 1'b1;
            cmd.op    = tabOp[i];
            cmd.data  = tabData[i];
            @(posedge clk);
            #2;
            cmd.valid = 1'b0;
            repeat (tabWait[i]) @(posedge clk);
            @(negedge clk);
            checkValue("revolutions", revolutions, tabRev[i]);   // table's own count.
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/motorPkg.sv
verilog/motorCmdDecoder.sv
verilog/stepGenerator.sv
verilog/phaseDriver.sv
verilog/motorTop.sv
testbench/motorTop_sva.sv
testbench/motorTb.sv
